// ==== cpu_testdata.txt ====
# T name starts a test, I word issues an instruction (hex), B is one idle cycle.
# W reg data expects a write-back of data to register reg, both in hex.
T alu
I 910000F0
W 1 000000F0
I 92008023
W 2 00008023
B
I 8310FFFF
W 3 000000EF
I 14120000
W 4 00008113
B
I 25120000
W 5 FFFF80CD
I 36130000
W 6 000000E0
B
I 47120000
W 7 000080F3
I 58130000
W 8 0000001F
B
I 69120000
W 9 00000780
I 7A520000
W A 1FFFF019
T fwd
I 91000010
W 1 00000010
I 82100001
W 2 00000011
I 13120000
W 3 00000021
I 54320000
W 4 00000030
I 95000001
W 5 00000001
I 95000002
W 5 00000002
I 16550000
W 6 00000004
T store_load
I 97000040
W 7 00000040
I 9800BEEF
W 8 0000BEEF
I B0780004
B
I A9700004
W 9 0000BEEF
T load_use
I AA700004
W A 0000BEEF
I 8BA00001
W B 0000BEF0
I 1CAB0000
W C 00017DDF
T nop
I 01230000
I C1120000
I F3450000
I 9D000005
W D 00000005

// ==== src.f ====
cpu_pkg.sv
pipe_if.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
data_ram.sv
result_stage.sv
cpu_core.sv
tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps -f src.f --top-module tb_cpu_core || exit 1
out=$(./obj_dir/Vtb_cpu_core)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1

// ==== tb_cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_cpu_core;

  logic               clk = 1'b0;
  logic               rst;
  logic               instr_valid;
  cpu_pkg::instr_t    instr;
  logic               wb_valid;
  cpu_pkg::reg_addr_t wb_reg;
  cpu_pkg::word_t     wb_data;

  string              lines[$];
  cpu_pkg::reg_addr_t exp_reg_q[$];
  cpu_pkg::word_t     exp_data_q[$];
  string              test_name;
  logic               test_open = 1'b0;
  int                 test_err_base = 0;
  int                 errors = 0;
  int                 tests_run = 0;
  int                 tests_failed = 0;
  int                 cycle_count = 0;
  int                 cycle_limit = 0;

  cpu_core dut0 (
    .clk_i(clk),
    .rst_i(rst),
    .instr_valid_i(instr_valid),
    .instr_i(instr),
    .wb_valid_o(wb_valid),
    .wb_reg_o(wb_reg),
    .wb_data_o(wb_data)
  );

  always #5 clk = ~clk;

  task automatic check_reg(cpu_pkg::reg_addr_t expected, cpu_pkg::reg_addr_t actual);
    if (actual !== expected)
    begin
      $display("mismatch at %0t: write-back to r%0d, expected r%0d", $time, actual, expected);
      errors++;
    end
  endtask

  task automatic check_data(cpu_pkg::word_t expected, cpu_pkg::word_t actual);
    if (actual !== expected)
    begin
      $display("mismatch at %0t: write-back data %h, expected %h", $time, actual, expected);
      errors++;
    end
  endtask

  // Outputs settle after the rising edge, so they are sampled on the falling one.
  always @(negedge clk)
  begin
    if (wb_valid === 1'b1)
    begin
      if (exp_reg_q.size() == 0)
      begin
        $display("write-back of %h to r%0d at %0t while none was expected", wb_data, wb_reg,
                 $time);
        errors++;
      end
      else
      begin
        check_reg(exp_reg_q.pop_front(), wb_reg);
        check_data(exp_data_q.pop_front(), wb_data);
      end
    end
  end

  function automatic string trim_eol(string s);
    string      t;
    logic [7:0] c;
    t = s;
    while (t.len() > 0)
    begin
      c = t.getc(t.len() - 1);
      if (c != 8'h0a && c != 8'h0d && c != " ")
        break;
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  task automatic load_testdata();
    int    fd;
    string line;
    fd = $fopen("cpu_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("could not open cpu_testdata.txt");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
        lines.push_back(line);
      $fclose(fd);
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  task automatic issue_instr(cpu_pkg::instr_t word);
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = word;
  endtask

  task automatic report_test();
    tests_run++;
    if (errors == test_err_base)
      $display("test %s: ok", test_name);
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_err_base);
    end
  endtask

  task automatic finish_test();
    cpu_pkg::reg_addr_t left_reg;
    cpu_pkg::word_t     left_data;
    repeat (4) drive_idle();  // Three stages to write-back, then the sampling edge.
    while (exp_reg_q.size() != 0)
    begin
      left_reg  = exp_reg_q.pop_front();
      left_data = exp_data_q.pop_front();
      $display("expected write-back of %h to r%0d never arrived", left_data, left_reg);
      errors++;
    end
    report_test();
    test_open = 1'b0;
  endtask

  task automatic run_reset_test();
    test_name     = "reset";
    test_err_base = errors;
    instr_valid   = 1'b1;  // An LDI r1 strobed during reset never reaches write-back.
    instr         = 32'h910000AA;
    for (int i = 0; i < 6; i++)
    begin
      @(posedge clk);
      #1;
      if (i == 2)
      begin
        rst         = 1'b0;  // Released after the third edge.
        instr_valid = 1'b0;
      end
      if (wb_valid !== 1'b0)
      begin
        $display("wb_valid_o is %b at %0t, it must stay low around reset", wb_valid, $time);
        errors++;
      end
    end
    report_test();
  endtask

  task automatic run_line(string line);
    logic [7:0]         kind;
    cpu_pkg::instr_t    word;
    cpu_pkg::reg_addr_t wreg;
    cpu_pkg::word_t     wdata;
    int                 n;
    kind = line.getc(0);
    n    = 0;
    case (kind)
      "T":
      begin
        if (test_open)
          finish_test();
        test_name     = trim_eol(line.substr(2, line.len() - 1));
        test_err_base = errors;
        test_open     = 1'b1;
        n             = 1;
      end
      "I":
      begin
        n = $sscanf(line, "I %h", word);
        if (n == 1)
          issue_instr(word);
      end
      "B":
      begin
        drive_idle();
        n = 1;
      end
      "W":
      begin
        n = $sscanf(line, "W %h %h", wreg, wdata);
        if (n == 2)
        begin
          exp_reg_q.push_back(wreg);
          exp_data_q.push_back(wdata);
        end
      end
      "#", 8'h0a, 8'h0d, 8'h00: n = 1;  // Comments and blank lines.
      default: n = 0;
    endcase
    if (n == 0)
    begin
      $display("could not read data file line: %s", trim_eol(line));
      errors++;
    end
  endtask

  // Ends the run if the stimulus stalls.
  initial
  begin
    while (cycle_limit == 0 || cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped after %0d cycles without finishing", cycle_count);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    load_testdata();
    cycle_limit = lines.size() + 20;
    run_reset_test();
    foreach (lines[i])
      run_line(lines[i]);
    if (test_open)
      finish_test();
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_run > 1)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_core (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire logic            instr_valid_i,
  input  wire cpu_pkg::instr_t instr_i,
  output logic                 wb_valid_o,
  output cpu_pkg::reg_addr_t   wb_reg_o,
  output cpu_pkg::word_t       wb_data_o
);

  cpu_pkg::reg_addr_t rd_addr_a;
  cpu_pkg::reg_addr_t rd_addr_b;
  cpu_pkg::word_t     rd_data_a;
  cpu_pkg::word_t     rd_data_b;
  logic               ram_we;
  cpu_pkg::ram_addr_t ram_addr;
  cpu_pkg::word_t     ram_wdata;
  cpu_pkg::word_t     ram_rdata;

  pipe_if de_bus();
  pipe_if er_bus();

  decode_stage decode0 (.clk_i(clk_i), .rst_i(rst_i),
                        .instr_valid_i(instr_valid_i),
                        .instr_i(instr_i),
                        .rd_addr_a_o(rd_addr_a),
                        .rd_addr_b_o(rd_addr_b),
                        .rd_data_a_i(rd_data_a),
                        .rd_data_b_i(rd_data_b),
                        .out(de_bus.src));

  // Written from the result stage outputs.
  reg_file regs0 (.clk_i(clk_i),
                  .rd_addr_a_i(rd_addr_a),
                  .rd_addr_b_i(rd_addr_b),
                  .rd_data_a_o(rd_data_a),
                  .rd_data_b_o(rd_data_b),
                  .wr_en_i(wb_valid_o),
                  .wr_addr_i(wb_reg_o),
                  .wr_data_i(wb_data_o));

  execute_stage exe0 (.clk_i(clk_i), .rst_i(rst_i),
                      .in(de_bus.dst),
                      .out(er_bus.src),
                      .fwd_en_i(wb_valid_o),
                      .fwd_addr_i(wb_reg_o),
                      .fwd_data_i(wb_data_o),
                      .ram_we_o(ram_we),
                      .ram_addr_o(ram_addr),
                      .ram_wdata_o(ram_wdata));

  data_ram ram0 (.clk_i(clk_i),
                 .we_i(ram_we),
                 .addr_i(ram_addr),
                 .wdata_i(ram_wdata),
                 .rdata_o(ram_rdata));

  result_stage res0 (.clk_i(clk_i), .rst_i(rst_i),
                     .in(er_bus.dst),
                     .ram_rdata_i(ram_rdata),
                     .wb_valid_o(wb_valid_o),
                     .wb_reg_o(wb_reg_o),
                     .wb_data_o(wb_data_o));

endmodule

`default_nettype wire

// ==== result_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module result_stage (
  input  wire logic           clk_i,
  input  wire logic           rst_i,
  pipe_if.dst                 in,
  input  wire cpu_pkg::word_t ram_rdata_i,
  output logic                wb_valid_o,
  output cpu_pkg::reg_addr_t  wb_reg_o,
  output cpu_pkg::word_t      wb_data_o
);

  logic               valid_q;
  logic               wr_en_q;
  cpu_pkg::opcode_t   op_q;
  cpu_pkg::reg_addr_t rd_q;
  cpu_pkg::word_t     alu_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_q <= 1'b0;
    else
      valid_q <= in.valid;
  end

  always_ff @(posedge clk_i)
  begin
    wr_en_q <= in.wr_en;
    op_q    <= in.op;
    rd_q    <= in.rd;
    alu_q   <= in.a;
  end

  // RAM read data lands in the same cycle as this stage's registers.
  assign wb_valid_o = valid_q && wr_en_q;
  assign wb_reg_o   = rd_q;
  assign wb_data_o  = (op_q == cpu_pkg::OP_LD) ? ram_rdata_i : alu_q;

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module data_ram (
  input  wire logic               clk_i,
  input  wire logic               we_i,
  input  wire cpu_pkg::ram_addr_t addr_i,
  input  wire cpu_pkg::word_t     wdata_i,
  output cpu_pkg::word_t          rdata_o
);

  cpu_pkg::word_t mem [cpu_pkg::RAM_DEPTH];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem[addr_i] <= wdata_i;
  end

  // Read every cycle. On a write to the same word the old value comes out.
  always_ff @(posedge clk_i)
  begin
    rdata_o <= mem[addr_i];
  end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  pipe_if.dst                     in,
  pipe_if.src                     out,
  input  wire logic               fwd_en_i,
  input  wire cpu_pkg::reg_addr_t fwd_addr_i,
  input  wire cpu_pkg::word_t     fwd_data_i,
  output logic                    ram_we_o,
  output cpu_pkg::ram_addr_t      ram_addr_o,
  output cpu_pkg::word_t          ram_wdata_o
);

  logic               valid_q;
  cpu_pkg::opcode_t   op_q;
  cpu_pkg::reg_addr_t rd_q;
  logic               wr_en_q;
  cpu_pkg::word_t     a_q;
  cpu_pkg::word_t     b_q;
  cpu_pkg::word_t     imm_q;
  cpu_pkg::reg_addr_t ra_q;
  cpu_pkg::reg_addr_t rb_q;

  cpu_pkg::word_t     a_fwd;
  cpu_pkg::word_t     b_fwd;
  cpu_pkg::word_t     alu_res;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_q <= 1'b0;
    else
      valid_q <= in.valid;
  end

  always_ff @(posedge clk_i)
  begin
    op_q    <= in.op;
    rd_q    <= in.rd;
    wr_en_q <= in.wr_en;
    a_q     <= in.a;
    b_q     <= in.b;
    imm_q   <= in.imm;
    ra_q    <= in.ra;
    rb_q    <= in.rb;
  end

  // The result stage holds the next older instruction, load data included.
  assign a_fwd = (fwd_en_i && (fwd_addr_i == ra_q)) ? fwd_data_i : a_q;
  assign b_fwd = (fwd_en_i && (fwd_addr_i == rb_q)) ? fwd_data_i : b_q;

  always_comb
  begin
    case (op_q)
      cpu_pkg::OP_ADD:  alu_res = a_fwd + b_fwd;
      cpu_pkg::OP_SUB:  alu_res = a_fwd - b_fwd;
      cpu_pkg::OP_AND:  alu_res = a_fwd & b_fwd;
      cpu_pkg::OP_OR:   alu_res = a_fwd | b_fwd;
      cpu_pkg::OP_XOR:  alu_res = a_fwd ^ b_fwd;
      cpu_pkg::OP_SHL:  alu_res = a_fwd << b_fwd[cpu_pkg::SHIFT_BITS-1:0];
      cpu_pkg::OP_SHR:  alu_res = a_fwd >> b_fwd[cpu_pkg::SHIFT_BITS-1:0];
      cpu_pkg::OP_LDI:  alu_res = imm_q;
      cpu_pkg::OP_ADDI,
      cpu_pkg::OP_LD,
      cpu_pkg::OP_ST:   alu_res = a_fwd + imm_q;  // Also the memory address.
      default:          alu_res = '0;
    endcase
  end

  // Word address into the data RAM. Upper bits are ignored.
  assign ram_we_o    = valid_q && (op_q == cpu_pkg::OP_ST);
  assign ram_addr_o  = alu_res[cpu_pkg::RAM_AW-1:0];
  assign ram_wdata_o = b_fwd;

  assign out.valid = valid_q;
  assign out.op    = op_q;
  assign out.rd    = rd_q;
  assign out.wr_en = wr_en_q;
  assign out.a     = alu_res;
  assign out.b     = b_fwd;
  assign out.imm   = imm_q;
  assign out.ra    = ra_q;
  assign out.rb    = rb_q;

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               instr_valid_i,
  input  wire cpu_pkg::instr_t    instr_i,
  output cpu_pkg::reg_addr_t      rd_addr_a_o,
  output cpu_pkg::reg_addr_t      rd_addr_b_o,
  input  wire cpu_pkg::word_t     rd_data_a_i,
  input  wire cpu_pkg::word_t     rd_data_b_i,
  pipe_if.src                     out
);

  localparam int OP_W  = $bits(cpu_pkg::opcode_t);
  localparam int REG_W = $bits(cpu_pkg::reg_addr_t);
  localparam int EXT_W = cpu_pkg::WORD_W - cpu_pkg::IMM_W;

  logic                      valid_q;
  cpu_pkg::instr_t           instr_q;
  logic [OP_W-1:0]           op_bits;
  cpu_pkg::opcode_t          op;
  logic [cpu_pkg::IMM_W-1:0] imm_raw;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      valid_q <= 1'b0;
    else
      valid_q <= instr_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (instr_valid_i)
      instr_q <= instr_i;
  end

  assign op_bits = instr_q[cpu_pkg::OP_MSB -: OP_W];
  assign imm_raw = instr_q[cpu_pkg::IMM_W-1:0];

  // Everything past OP_ST is unassigned.
  assign op = (op_bits > cpu_pkg::OP_ST) ? cpu_pkg::OP_NOP : cpu_pkg::opcode_t'(op_bits);

  assign rd_addr_a_o = instr_q[cpu_pkg::RA_MSB -: REG_W];
  assign rd_addr_b_o = instr_q[cpu_pkg::RB_MSB -: REG_W];

  assign out.valid = valid_q;
  assign out.op    = op;
  assign out.rd    = instr_q[cpu_pkg::RD_MSB -: REG_W];
  assign out.wr_en = (op != cpu_pkg::OP_ST) && (op != cpu_pkg::OP_NOP);
  assign out.a     = rd_data_a_i;
  assign out.b     = rd_data_b_i;
  assign out.ra    = rd_addr_a_o;
  assign out.rb    = rd_addr_b_o;

  always_comb
  begin
    if (op == cpu_pkg::OP_LDI)
      out.imm = {{EXT_W{1'b0}}, imm_raw};
    else
      out.imm = {{EXT_W{imm_raw[cpu_pkg::IMM_W-1]}}, imm_raw};  // Sign extend.
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file (
  input  wire logic               clk_i,
  input  wire cpu_pkg::reg_addr_t rd_addr_a_i,
  input  wire cpu_pkg::reg_addr_t rd_addr_b_i,
  output cpu_pkg::word_t          rd_data_a_o,
  output cpu_pkg::word_t          rd_data_b_o,
  input  wire logic               wr_en_i,
  input  wire cpu_pkg::reg_addr_t wr_addr_i,
  input  wire cpu_pkg::word_t     wr_data_i
);

  cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

  logic hit_a;
  logic hit_b;

  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      regs[wr_addr_i] <= wr_data_i;
  end

  // Write-through. A read in the cycle of the write sees the new value,
  // which covers a consumer two instructions behind its producer.
  assign hit_a = wr_en_i && (wr_addr_i == rd_addr_a_i);
  assign hit_b = wr_en_i && (wr_addr_i == rd_addr_b_i);

  always_comb
  begin
    if (hit_a)
      rd_data_a_o = wr_data_i;
    else
      rd_data_a_o = regs[rd_addr_a_i];
  end

  always_comb
  begin
    if (hit_b)
      rd_data_b_o = wr_data_i;
    else
      rd_data_b_o = regs[rd_addr_b_i];
  end

endmodule

`default_nettype wire

// ==== pipe_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface pipe_if;

  logic               valid;
  cpu_pkg::opcode_t   op;
  cpu_pkg::reg_addr_t rd;
  logic               wr_en;   // Instruction writes rd.
  cpu_pkg::word_t     a;       // Operand a, or the ALU result after execute.
  cpu_pkg::word_t     b;
  cpu_pkg::word_t     imm;
  cpu_pkg::reg_addr_t ra;
  cpu_pkg::reg_addr_t rb;

  modport src (
    output valid, op, rd, wr_en,
    output a, b, imm,
    output ra, rb
  );

  modport dst (
    input valid, op, rd, wr_en,
    input a, b, imm,
    input ra, rb
  );

endinterface

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_AW     = 4;
  localparam int NUM_REGS   = 1 << REG_AW;
  localparam int RAM_AW     = 8;
  localparam int RAM_DEPTH  = 1 << RAM_AW;
  localparam int IMM_W      = 16;
  localparam int SHIFT_BITS = 5;

  // Instruction word layout. The immediate sits in the low IMM_W bits.
  localparam int OP_MSB = 31;
  localparam int RD_MSB = 27;
  localparam int RA_MSB = 23;
  localparam int RB_MSB = 19;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [WORD_W-1:0] instr_t;
  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [RAM_AW-1:0] ram_addr_t;

  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_SHL  = 4'h6,
    OP_SHR  = 4'h7,
    OP_ADDI = 4'h8,  // ra + sext(imm).
    OP_LDI  = 4'h9,  // zext(imm).
    OP_LD   = 4'hA,  // mem[ra + sext(imm)].
    OP_ST   = 4'hB   // mem[ra + sext(imm)] = rb.
  } opcode_t;

  // Codes 0xC to 0xF are not assigned and decode as OP_NOP.

endpackage

`default_nettype wire
